//--- logic/laser_defines.svh
`ifndef LASER_DEFINES_SVH
`define LASER_DEFINES_SVH

// 16x16 grid, one nibble per axis
`define LASER_COORD_W      4

// points per input frame
`define LASER_NPOINTS      40
`define LASER_ADDR_W       6

// covered when dx*dx + dy*dy <= this
`define LASER_RADIUS_SQ    16

// start centers, reloaded every frame
`define LASER_C1_X0        4
`define LASER_C1_Y0        7
`define LASER_C2_X0        11
`define LASER_C2_Y0        7

`define LASER_MAX_ROUNDS   6   // c1 then c2 per round

// start to done of one scan, NPOINTS + 2
`define LASER_EVAL_LAT     42

`endif

//--- logic/laser_pkg.sv
`include "laser_defines.svh"

package laser_pkg;

    typedef logic [`LASER_COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef logic [5:0] count_t;  // up to 40 hits

    typedef logic [`LASER_ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        s_load,
        s_eval,
        s_pick,
        s_report
    } state_e;

    // scored in this order, ties keep the earlier one
    typedef enum logic [2:0] {
        m_stay,
        m_up,
        m_down,
        m_left,
        m_right
    } move_e;

endpackage

//--- logic/laser_scan_if.sv
`timescale 1ns/1ps

interface laser_scan_if;

    laser_pkg::point_t cand;   // candidate center under test
    laser_pkg::point_t other;  // the other circle, current position
    logic              start;
    laser_pkg::addr_t  addr;
    laser_pkg::point_t pt;
    laser_pkg::count_t count;
    logic              done;

    modport ctrl (
        output cand,
        output other,
        output start,
        input  count,
        input  done
    );

    modport eval (
        input  cand,
        input  other,
        input  start,
        input  pt,
        output addr,
        output count,
        output done
    );

    modport store (
        input  addr,
        output pt
    );

endinterface

//--- logic/laser_point_store.sv
`timescale 1ns/1ps
`include "laser_defines.svh"

module laser_point_store (
    input  logic              CLK,
    input  logic              load,
    input  laser_pkg::point_t wr_pt,
    laser_scan_if.store       scan
);

    localparam laser_pkg::addr_t last_addr = laser_pkg::addr_t'(`LASER_NPOINTS - 1);

    laser_pkg::point_t mem [0:`LASER_NPOINTS-1];
    laser_pkg::addr_t  wr_ptr;

    // write side, one point per load cycle
    always_ff @(posedge CLK)
    begin
        if (load)
        begin
            mem[wr_ptr] <= wr_pt;
            if (wr_ptr == last_addr)
            begin
                wr_ptr <= '0;
            end
            else
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
        else
        begin
            wr_ptr <= '0;  // idle between frames
        end
    end

    // registered read, pt one cycle after addr
    always_ff @(posedge CLK)
    begin
        scan.pt <= mem[scan.addr];
    end

endmodule

//--- logic/laser_cover_eval.sv
`timescale 1ns/1ps
`include "laser_defines.svh"

module laser_cover_eval (
    input  logic        CLK,
    input  logic        RST,
    laser_scan_if.eval  scan
);

    localparam laser_pkg::addr_t last_addr = laser_pkg::addr_t'(`LASER_NPOINTS - 1);

    logic              issue;    // addr valid this cycle
    logic              pt_vld;   // store output valid
    logic              pt_last;
    logic              hit;
    logic              done_q;
    logic              in_cand;
    logic              in_other;
    laser_pkg::addr_t  addr_q;
    laser_pkg::count_t acc;

    function automatic logic in_radius(laser_pkg::point_t p, laser_pkg::point_t c);
        laser_pkg::coord_t        dx;
        laser_pkg::coord_t        dy;
        logic [2*`LASER_COORD_W:0] d2;
        dx = (p.x > c.x) ? p.x - c.x : c.x - p.x;
        dy = (p.y > c.y) ? p.y - c.y : c.y - p.y;
        d2 = dx * dx + dy * dy;
        return d2 <= `LASER_RADIUS_SQ;
    endfunction

    assign in_cand  = in_radius(scan.pt, scan.cand);
    assign in_other = in_radius(scan.pt, scan.other);

    // stages: addr, pt, hit
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            issue   <= 1'b0;
            addr_q  <= '0;
            pt_vld  <= 1'b0;
            pt_last <= 1'b0;
            hit     <= 1'b0;
            done_q  <= 1'b0;
            acc     <= '0;
        end
        else
        begin
            if (scan.start)
            begin
                issue  <= 1'b1;
                addr_q <= '0;
            end
            else if (issue)
            begin
                if (addr_q == last_addr)
                begin
                    issue <= 1'b0;
                end
                else
                begin
                    addr_q <= addr_q + 1'b1;
                end
            end

            pt_vld  <= issue;
            pt_last <= issue && (addr_q == last_addr);
            hit     <= pt_vld && in_cand && !in_other;
            done_q  <= pt_last;

            if (scan.start)
            begin
                acc <= '0;
            end
            else
            begin
                acc <= acc + laser_pkg::count_t'(hit);
            end
        end
    end

    assign scan.addr  = addr_q;
    assign scan.count = acc + laser_pkg::count_t'(hit);  // last hit folded in
    assign scan.done  = done_q;

endmodule

//--- logic/laser_ctrl.sv
`timescale 1ns/1ps
`include "laser_defines.svh"

module laser_ctrl (
    input  logic              CLK,
    input  logic              RST,
    output logic              load,
    output laser_pkg::coord_t C1X,
    output laser_pkg::coord_t C1Y,
    output laser_pkg::coord_t C2X,
    output laser_pkg::coord_t C2Y,
    output logic              DONE,
    laser_scan_if.ctrl        scan
);

    localparam laser_pkg::addr_t last_addr = laser_pkg::addr_t'(`LASER_NPOINTS - 1);
    localparam int round_w = $clog2(`LASER_MAX_ROUNDS + 1);
    localparam logic [round_w-1:0] last_round = round_w'(`LASER_MAX_ROUNDS - 1);

    localparam laser_pkg::point_t c1_start = '{
        x: laser_pkg::coord_t'(`LASER_C1_X0),
        y: laser_pkg::coord_t'(`LASER_C1_Y0)
    };
    localparam laser_pkg::point_t c2_start = '{
        x: laser_pkg::coord_t'(`LASER_C2_X0),
        y: laser_pkg::coord_t'(`LASER_C2_Y0)
    };

    laser_pkg::state_e state;
    laser_pkg::addr_t  cnt;
    laser_pkg::point_t c1;
    laser_pkg::point_t c2;
    laser_pkg::point_t cur_c;
    laser_pkg::move_e  move;
    laser_pkg::move_e  nxt;
    laser_pkg::move_e  best_move;
    laser_pkg::count_t best_cnt;
    logic              second;   // 0 while improving c1
    logic              moved;
    logic              round_moved;
    logic              start_q;
    logic [round_w-1:0] rounds;

    function automatic laser_pkg::point_t shift(laser_pkg::point_t c, laser_pkg::move_e m);
        laser_pkg::point_t p;
        p = c;
        case (m)
            laser_pkg::m_up:    p.y = c.y + 1'b1;
            laser_pkg::m_down:  p.y = c.y - 1'b1;
            laser_pkg::m_left:  p.x = c.x - 1'b1;
            laser_pkg::m_right: p.x = c.x + 1'b1;
            default:            p = c;
        endcase
        return p;
    endfunction

    // next on-grid move after cur, stay when none is left
    function automatic laser_pkg::move_e next_move(laser_pkg::move_e cur,
                                                   laser_pkg::point_t c);
        laser_pkg::move_e m;
        m = laser_pkg::m_stay;
        if (cur == laser_pkg::m_stay && c.y != '1)
            m = laser_pkg::m_up;
        else if (cur <= laser_pkg::m_up && c.y != '0)
            m = laser_pkg::m_down;
        else if (cur <= laser_pkg::m_down && c.x != '0)
            m = laser_pkg::m_left;
        else if (cur <= laser_pkg::m_left && c.x != '1)
            m = laser_pkg::m_right;
        return m;
    endfunction

    assign cur_c       = second ? c2 : c1;
    assign nxt         = next_move(move, cur_c);
    assign round_moved = moved || (best_move != laser_pkg::m_stay);

    assign scan.cand  = shift(cur_c, move);
    assign scan.other = second ? c1 : c2;
    assign scan.start = start_q;

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            state     <= laser_pkg::s_load;
            cnt       <= '0;
            load      <= 1'b0;
            start_q   <= 1'b0;
            DONE      <= 1'b0;
            C1X       <= '0;
            C1Y       <= '0;
            C2X       <= '0;
            C2Y       <= '0;
            c1        <= c1_start;
            c2        <= c2_start;
            second    <= 1'b0;
            move      <= laser_pkg::m_stay;
            best_move <= laser_pkg::m_stay;
            best_cnt  <= '0;
            moved     <= 1'b0;
            rounds    <= '0;
        end
        else
        begin
            start_q <= 1'b0;
            DONE    <= 1'b0;
            case (state)
                laser_pkg::s_load:
                begin
                    if (!load)
                    begin
                        load <= 1'b1;  // window opens a cycle late
                    end
                    else if (cnt == last_addr)
                    begin
                        load    <= 1'b0;
                        cnt     <= '0;
                        move    <= laser_pkg::m_stay;
                        start_q <= 1'b1;
                        state   <= laser_pkg::s_eval;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
                laser_pkg::s_eval:
                begin
                    if (scan.done)
                    begin
                        // strictly higher wins
                        if (move == laser_pkg::m_stay || scan.count > best_cnt)
                        begin
                            best_cnt  <= scan.count;
                            best_move <= move;
                        end
                        if (nxt != laser_pkg::m_stay)
                        begin
                            move    <= nxt;
                            start_q <= 1'b1;
                        end
                        else
                        begin
                            state <= laser_pkg::s_pick;
                        end
                    end
                end
                laser_pkg::s_pick:
                begin
                    move <= laser_pkg::m_stay;
                    if (!second)
                    begin
                        c1      <= shift(c1, best_move);
                        moved   <= round_moved;
                        second  <= 1'b1;
                        start_q <= 1'b1;
                        state   <= laser_pkg::s_eval;
                    end
                    else
                    begin
                        c2 <= shift(c2, best_move);
                        if (!round_moved || rounds == last_round)
                        begin
                            state <= laser_pkg::s_report;
                        end
                        else
                        begin
                            second  <= 1'b0;
                            moved   <= 1'b0;
                            rounds  <= rounds + 1'b1;
                            start_q <= 1'b1;
                            state   <= laser_pkg::s_eval;
                        end
                    end
                end
                laser_pkg::s_report:
                begin
                    DONE   <= 1'b1;
                    C1X    <= c1.x;
                    C1Y    <= c1.y;
                    C2X    <= c2.x;
                    C2Y    <= c2.y;
                    c1     <= c1_start;  // next frame starts fresh
                    c2     <= c2_start;
                    second <= 1'b0;
                    moved  <= 1'b0;
                    rounds <= '0;
                    state  <= laser_pkg::s_load;
                end
                default:
                begin
                    state <= laser_pkg::s_load;
                end
            endcase
        end
    end

endmodule

//--- logic/laser.sv
`timescale 1ns/1ps

module laser (
    input  logic              CLK,
    input  logic              RST,
    input  laser_pkg::coord_t X,
    input  laser_pkg::coord_t Y,
    output laser_pkg::coord_t C1X,
    output laser_pkg::coord_t C1Y,
    output laser_pkg::coord_t C2X,
    output laser_pkg::coord_t C2Y,
    output logic              DONE
);

    logic load;  // store write enable from ctrl

    laser_scan_if scan0 ();

    laser_ctrl ctrl0 (
        .CLK  (CLK),
        .RST  (RST),
        .load (load),
        .C1X  (C1X),
        .C1Y  (C1Y),
        .C2X  (C2X),
        .C2Y  (C2Y),
        .DONE (DONE),
        .scan (scan0.ctrl)
    );

    // x in the upper nibble of point_t
    laser_point_store store0 (
        .CLK   (CLK),
        .load  (load),
        .wr_pt ({X, Y}),
        .scan  (scan0.store)
    );

    laser_cover_eval eval0 (
        .CLK  (CLK),
        .RST  (RST),
        .scan (scan0.eval)
    );

endmodule

//--- sim/laser_chk.sv
`timescale 1ns/1ps
`include "laser_defines.svh"

module laser_chk (
    input logic              CLK,
    input logic              RST,
    input logic              DONE,
    input laser_pkg::state_e state,
    input logic              start,
    input logic              done
);

    logic busy;  // scan in flight

    always_ff @(posedge CLK)
    begin
        if (RST)
            busy <= 1'b0;
        else if (start)
            busy <= 1'b1;
        else if (done)
            busy <= 1'b0;
    end

    done_single: assert property (@(posedge CLK) disable iff (RST) DONE |=> !DONE)
        else $error("DONE high on two cycles in a row");

    eval_latency: assert property (@(posedge CLK) disable iff (RST)
        start |-> ##`LASER_EVAL_LAT done)
        else $error("eval done not at fixed latency");

    no_overlap: assert property (@(posedge CLK) disable iff (RST) start |-> !busy)
        else $error("start while scan in flight");

    // the evaluator must finish while the controller still waits for it
    done_in_eval: assert property (@(posedge CLK) disable iff (RST)
        done |-> state == laser_pkg::s_eval)
        else $error("eval done outside eval state");

endmodule

bind laser_ctrl laser_chk chk0 (
    .CLK   (CLK),
    .RST   (RST),
    .DONE  (DONE),
    .state (state),
    .start (start_q),
    .done  (scan.done)
);

//--- sim/laser_tb.sv
`timescale 1ns/1ps
`include "laser_defines.svh"

module laser_tb;

    localparam int n_frames    = 4;
    localparam int frame_words = `LASER_NPOINTS + 4;  // points, then c1x c1y c2x c2y
    localparam int clk_ns      = 40;

    // worst case per frame, doubled
    localparam longint watchdog_ns = longint'(n_frames)
        * (`LASER_NPOINTS + 2 * `LASER_MAX_ROUNDS * 2 * 5 * (`LASER_EVAL_LAT + 2))
        * clk_ns * 2;

    logic              CLK;
    logic              RST;
    laser_pkg::coord_t X;
    laser_pkg::coord_t Y;
    laser_pkg::coord_t C1X;
    laser_pkg::coord_t C1Y;
    laser_pkg::coord_t C2X;
    laser_pkg::coord_t C2Y;
    logic              DONE;

    logic [7:0] tdata [0:n_frames*frame_words-1];

    // last reported centers, must hold until the next DONE
    laser_pkg::coord_t held_c1x;
    laser_pkg::coord_t held_c1y;
    laser_pkg::coord_t held_c2x;
    laser_pkg::coord_t held_c2y;

    laser dut0 (
        .CLK  (CLK),
        .RST  (RST),
        .X    (X),
        .Y    (Y),
        .C1X  (C1X),
        .C1Y  (C1Y),
        .C2X  (C2X),
        .C2Y  (C2Y),
        .DONE (DONE)
    );

    initial
    begin
        CLK = 1'b0;
    end

    always #(clk_ns/2) CLK = ~CLK;

    task automatic check_coord(input string name, input laser_pkg::coord_t got,
                               input laser_pkg::coord_t exp);
        if (got !== exp)
        begin
            $display("ERROR %0t ns %s got %0d expected %0d", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "coordinate mismatch");
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR %0t ns %s got %b expected %b", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "strobe mismatch");
        end
    endtask

    task automatic check_held();
        check_coord("C1X", C1X, held_c1x);
        check_coord("C1Y", C1Y, held_c1y);
        check_coord("C2X", C2X, held_c2x);
        check_coord("C2Y", C2Y, held_c2y);
    endtask

    // one point per falling edge, outputs must stay put meanwhile
    task automatic drive_points(input int base);
        for (int k = 0; k < `LASER_NPOINTS; k++)
        begin
            @(negedge CLK);
            check_done("DONE", DONE, 1'b0);
            check_held();
            X = laser_pkg::coord_t'(tdata[base + k][7:4]);
            Y = laser_pkg::coord_t'(tdata[base + k][3:0]);
        end
    endtask

    task automatic wait_done();
        @(negedge CLK);
        while (DONE !== 1'b1)
        begin
            check_held();
            @(negedge CLK);
        end
    endtask

    task automatic check_result(input int base);
        int e;
        e = base + `LASER_NPOINTS;
        check_coord("C1X", C1X, laser_pkg::coord_t'(tdata[e][3:0]));
        check_coord("C1Y", C1Y, laser_pkg::coord_t'(tdata[e + 1][3:0]));
        check_coord("C2X", C2X, laser_pkg::coord_t'(tdata[e + 2][3:0]));
        check_coord("C2Y", C2Y, laser_pkg::coord_t'(tdata[e + 3][3:0]));
        held_c1x = C1X;
        held_c1y = C1Y;
        held_c2x = C2X;
        held_c2y = C2Y;
    endtask

    initial
    begin
        RST      = 1'b1;
        X        = '0;
        Y        = '0;
        held_c1x = '0;  // reset values
        held_c1y = '0;
        held_c2x = '0;
        held_c2y = '0;
        $readmemh("sim/laser_testdata.txt", tdata);
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        for (int f = 0; f < n_frames; f++)
        begin
            drive_points(f * frame_words);
            wait_done();
            check_result(f * frame_words);
        end

        // DONE must drop after one cycle
        @(negedge CLK);
        check_done("DONE", DONE, 1'b0);
        check_held();

        $display("Test OK");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout, DONE never arrived for the current frame");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sim/laser_testdata.txt
// per frame: five lines of eight points, byte = x nibble then y nibble
// then one line of expected c1x c1y c2x c2y
// frame 1, clusters above c1 and right of c2
4c 4d f9 f4 4c 4d f9 f4
4c 4d f9 f4 4c 4d f9 f4
4c 4d f9 f4 4c 4d f9 f4
4c 4d f9 f4 4c 4d f9 f4
4c 4d f9 f4 4c 4d f9 f4
04 09 0d 07
// frame 2, frame 1 mirrored about row 7
42 41 f5 fa 42 41 f5 fa
42 41 f5 fa 42 41 f5 fa
42 41 f5 fa 42 41 f5 fa
42 41 f5 fa 42 41 f5 fa
42 41 f5 fa 42 41 f5 fa
04 05 0d 07
// frame 3, c1 walks to the left edge
06 08 14 1a 04 0a 13 1b
06 08 14 1a 04 0a 13 1b
06 08 14 1a 04 0a 13 1b
06 08 14 1a 04 0a 03 0b
03 0b 03 0b 03 0b 03 0b
00 07 0b 07
// frame 4, corners only, nothing reachable
00 ff 0f f0 00 ff 0f f0
00 ff 0f f0 00 ff 0f f0
00 ff 0f f0 00 ff 0f f0
00 ff 0f f0 00 ff 0f f0
00 ff 0f f0 00 ff 0f f0
04 07 0b 07

//--- laser.f
+incdir+logic
logic/laser_pkg.sv
logic/laser_scan_if.sv
logic/laser_point_store.sv
logic/laser_cover_eval.sv
logic/laser_ctrl.sv
logic/laser.sv
sim/laser_chk.sv
sim/laser_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= laser_tb
FILELIST   ?= laser.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
